//--- source/xbar_pkg.sv
// shared sizes and types of the flow crossbar
package xbar_pkg;

  // number of push flows feeding the crossbar
  localparam int num_push_flows = 4;

  // number of pop flows leaving the crossbar
  localparam int num_pop_flows = 4;

  // width of one item in bits
  localparam int data_width = 16;

  // index of a push flow
  // also the arbitration pointer width
  typedef logic [$clog2(num_push_flows)-1:0] push_id_t;

  // index of a pop flow, carried with every item
  typedef logic [$clog2(num_pop_flows)-1:0] dest_id_t;

  // item payload
  typedef logic [data_width-1:0] flow_data_t;

endpackage

//--- source/flow_if.sv
`timescale 1ns/10ps

// one valid/ready flow link with payload and destination id
// transfer happens on a clock edge with valid and ready both high
interface flow_if;

  // sender side
  logic valid;
  xbar_pkg::flow_data_t data;
  xbar_pkg::dest_id_t dest;

  // receiver side
  logic ready;

  // drives the item, sees back-pressure
  modport sender (output valid, output data, output dest, input ready);

  // takes the item, drives back-pressure
  modport receiver (input valid, input data, input dest, output ready);

endinterface

//--- source/flow_reg.sv
`timescale 1ns/10ps

// one-entry pipeline register on a flow link
// full throughput: the entry reloads in the same cycle it drains
module flow_reg (
  input logic clk,
  input logic rst_n,
  flow_if.receiver in,
  flow_if.sender out
);

  // entry occupied
  logic full_q;

  // held item and its destination
  xbar_pkg::flow_data_t data_q;
  xbar_pkg::dest_id_t dest_q;

  // take a new item when empty or when the held one leaves now
  assign in.ready = !full_q || out.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (in.ready) begin
      // refill on arrival, otherwise the entry drains
      full_q <= in.valid;
    end
  end

  // payload moves only on an accepted transfer, so held data stays put
  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      data_q <= in.data;
      dest_q <= in.dest;
    end
  end

  assign out.valid = full_q;
  assign out.data = data_q;
  assign out.dest = dest_q;

endmodule

//--- source/flow_demux.sv
`timescale 1ns/10ps

// steers one push flow onto the lane picked by its destination id
// purely combinational, valid never looks at ready
module flow_demux (
  flow_if.receiver in,
  flow_if.sender lanes [xbar_pkg::num_pop_flows]
);

  // ready of each lane, gathered so it can be picked by dest
  logic [xbar_pkg::num_pop_flows-1:0] lane_ready;

  for (genvar j = 0; j < xbar_pkg::num_pop_flows; j++) begin : gen_lane
    // only the addressed lane sees valid
    // so one item can never be taken twice
    assign lanes[j].valid = in.valid && (in.dest == xbar_pkg::dest_id_t'(j));

    // payload fans out to every lane unchanged
    assign lanes[j].data = in.data;
    assign lanes[j].dest = in.dest;

    assign lane_ready[j] = lanes[j].ready;
  end

  // push side back-pressure comes from the addressed lane only
  assign in.ready = lane_ready[in.dest];

endmodule

//--- source/rr_arbiter.sv
`timescale 1ns/10ps

// round-robin grant over the push flows
// search starts one past the last served index
module rr_arbiter (
  input logic clk,
  input logic rst_n,
  input logic [xbar_pkg::num_push_flows-1:0] request,
  input logic advance,
  output logic [xbar_pkg::num_push_flows-1:0] grant
);

  // index served by the last completed transfer
  xbar_pkg::push_id_t last_q;

  // a grant is pending and its transfer has not happened yet
  logic locked_q;
  logic [xbar_pkg::num_push_flows-1:0] held_q;

  // grant the search would give this cycle
  logic [xbar_pkg::num_push_flows-1:0] fresh;

  always_comb begin
    xbar_pkg::push_id_t idx;
    logic found;
    fresh = '0;
    found = 1'b0;
    for (int k = 1; k <= xbar_pkg::num_push_flows; k++) begin
      // walk the ring starting after the last winner
      idx = xbar_pkg::push_id_t'((int'(last_q) + k) % xbar_pkg::num_push_flows);
      if (!found && request[idx]) begin
        fresh[idx] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // a stalled winner keeps its grant, a late requester cannot steal it
  assign grant = locked_q ? held_q : fresh;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // first search starts at index 0
      last_q <= xbar_pkg::push_id_t'(xbar_pkg::num_push_flows - 1);
      locked_q <= 1'b0;
      held_q <= '0;
    end else begin
      locked_q <= (|grant) && !advance;
      held_q <= grant;
      // pointer moves only when the granted item really left
      if (advance) begin
        for (int k = 0; k < xbar_pkg::num_push_flows; k++) begin
          if (grant[k]) begin
            last_q <= xbar_pkg::push_id_t'(k);
          end
        end
      end
    end
  end

endmodule

//--- source/flow_mux.sv
`timescale 1ns/10ps

// merges the lanes headed to one pop flow
// round-robin arbitration, optional register on the pop side
module flow_mux #(
  parameter bit register_pop_outputs = 1'b1
) (
  input logic clk,
  input logic rst_n,
  flow_if.receiver lanes [xbar_pkg::num_push_flows],
  flow_if.sender out
);

  // lane signals gathered into arrays for indexing
  logic [xbar_pkg::num_push_flows-1:0] lane_valid;
  xbar_pkg::flow_data_t lane_data [xbar_pkg::num_push_flows];
  xbar_pkg::dest_id_t lane_dest [xbar_pkg::num_push_flows];

  // one-hot grant and its encoded index
  logic [xbar_pkg::num_push_flows-1:0] grant;
  xbar_pkg::push_id_t sel;

  // merged item was taken this cycle
  logic advance;

  // merged flow ahead of the optional pop register
  flow_if merged ();

  for (genvar i = 0; i < xbar_pkg::num_push_flows; i++) begin : gen_lane
    assign lane_valid[i] = lanes[i].valid;
    assign lane_data[i] = lanes[i].data;
    assign lane_dest[i] = lanes[i].dest;
    // only the winner sees ready
    assign lanes[i].ready = grant[i] && merged.ready;
  end

  rr_arbiter u_arb (
    .clk(clk),
    .rst_n(rst_n),
    .request(lane_valid),
    .advance(advance),
    .grant(grant)
  );

  // one-hot to index
  always_comb begin
    sel = '0;
    for (int k = 0; k < xbar_pkg::num_push_flows; k++) begin
      if (grant[k]) begin
        sel = xbar_pkg::push_id_t'(k);
      end
    end
  end

  // cut-through from grant to valid in the same cycle
  assign merged.valid = |(grant & lane_valid);
  assign merged.data = lane_data[sel];
  assign merged.dest = lane_dest[sel];

  // arbiter moves on only after a real transfer
  assign advance = merged.valid && merged.ready;

  if (register_pop_outputs) begin : gen_pop_reg
    // adds one cycle, keeps pop data stable under back-pressure
    flow_reg u_pop_reg (
      .clk(clk),
      .rst_n(rst_n),
      .in(merged),
      .out(out)
    );
  end else begin : gen_pop_comb
    // valid stays up here only because the lanes hold their items
    assign out.valid = merged.valid;
    assign out.data = merged.data;
    assign out.dest = merged.dest;
    assign merged.ready = out.ready;
  end

endmodule

//--- source/flow_xbar.sv
`timescale 1ns/10ps

// flow crossbar, push flows steered to pop flows by destination id
// latency on an idle path is the number of enabled register stages
module flow_xbar #(
  parameter bit register_demux_outputs = 1'b1,
  parameter bit register_pop_outputs = 1'b1
) (
  input logic clk,
  input logic rst_n,
  input logic [xbar_pkg::num_push_flows-1:0] push_valid,
  output logic [xbar_pkg::num_push_flows-1:0] push_ready,
  input xbar_pkg::flow_data_t [xbar_pkg::num_push_flows-1:0] push_data,
  input xbar_pkg::dest_id_t [xbar_pkg::num_push_flows-1:0] push_dest_id,
  output logic [xbar_pkg::num_pop_flows-1:0] pop_valid,
  input logic [xbar_pkg::num_pop_flows-1:0] pop_ready,
  output xbar_pkg::flow_data_t [xbar_pkg::num_pop_flows-1:0] pop_data
);

  // push side: port adapter, demux, optional middle registers
  for (genvar i = 0; i < xbar_pkg::num_push_flows; i++) begin : gen_push
    flow_if push_link ();
    // demux outputs, one per pop flow
    flow_if lane [xbar_pkg::num_pop_flows] ();
    // links after the optional middle register
    flow_if hop [xbar_pkg::num_pop_flows] ();

    assign push_link.valid = push_valid[i];
    assign push_link.data = push_data[i];
    assign push_link.dest = push_dest_id[i];
    assign push_ready[i] = push_link.ready;

    flow_demux u_demux (
      .in(push_link),
      .lanes(lane)
    );

    for (genvar j = 0; j < xbar_pkg::num_pop_flows; j++) begin : gen_hop
      if (register_demux_outputs) begin : gen_mid_reg
        // breaks the path between demux and mux, one extra cycle
        flow_reg u_mid_reg (
          .clk(clk),
          .rst_n(rst_n),
          .in(lane[j]),
          .out(hop[j])
        );
      end else begin : gen_mid_comb
        assign hop[j].valid = lane[j].valid;
        assign hop[j].data = lane[j].data;
        assign hop[j].dest = lane[j].dest;
        assign lane[j].ready = hop[j].ready;
      end
    end
  end

  // pop side: gather lane j of every push flow, merge, adapt to ports
  for (genvar j = 0; j < xbar_pkg::num_pop_flows; j++) begin : gen_pop
    flow_if merge_lane [xbar_pkg::num_push_flows] ();
    flow_if pop_link ();

    for (genvar i = 0; i < xbar_pkg::num_push_flows; i++) begin : gen_cross
      assign merge_lane[i].valid = gen_push[i].hop[j].valid;
      assign merge_lane[i].data = gen_push[i].hop[j].data;
      assign merge_lane[i].dest = gen_push[i].hop[j].dest;
      assign gen_push[i].hop[j].ready = merge_lane[i].ready;
    end

    flow_mux #(
      .register_pop_outputs(register_pop_outputs)
    ) u_mux (
      .clk(clk),
      .rst_n(rst_n),
      .lanes(merge_lane),
      .out(pop_link)
    );

    // dest on the pop link always equals j, not a port
    assign pop_valid[j] = pop_link.valid;
    assign pop_data[j] = pop_link.data;
    assign pop_link.ready = pop_ready[j];
  end

endmodule

//--- sim/flow_xbar_checker.sv
`timescale 1ns/10ps

// concurrent assertions on the crossbar pop ports
// bound into every flow_xbar instance
module flow_xbar_checker (
  input logic clk,
  input logic rst_n,
  input logic [xbar_pkg::num_pop_flows-1:0] pop_valid,
  input logic [xbar_pkg::num_pop_flows-1:0] pop_ready,
  input xbar_pkg::flow_data_t [xbar_pkg::num_pop_flows-1:0] pop_data
);

  // a reset cycle empties every pop register
  pop_idle_in_reset: assert property (
    @(posedge clk) !rst_n |=> (pop_valid == '0)
  ) else $error("pop_valid high after a reset cycle");

  for (genvar j = 0; j < xbar_pkg::num_pop_flows; j++) begin : gen_pop
    // a stalled item stays offered until taken
    pop_valid_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      pop_valid[j] && !pop_ready[j] |=> pop_valid[j]
    ) else $error("pop %0d withdrew valid while stalled", j);

    // payload frozen while the consumer holds off
    pop_data_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      pop_valid[j] && !pop_ready[j] |=> $stable(pop_data[j])
    ) else $error("pop %0d changed data while stalled", j);
  end

endmodule

// attach to the DUT, pop side ports only
bind flow_xbar flow_xbar_checker u_checker (
  .clk(clk),
  .rst_n(rst_n),
  .pop_valid(pop_valid),
  .pop_ready(pop_ready),
  .pop_data(pop_data)
);

//--- sim/flow_xbar_tb.sv
`timescale 1ns/10ps

// testbench for the flow crossbar
// one expected queue per source and destination pair, filled at push time
module flow_xbar_tb;

  localparam int n_push = xbar_pkg::num_push_flows;
  localparam int n_pop = xbar_pkg::num_pop_flows;

  // items per source in each test
  localparam int route_items = 8;
  localparam int order_items = 50;
  localparam int stall_items = 50;
  localparam int fair_items = 16;

  // run limit grows with the total number of pushed items
  localparam int total_items =
    1 + n_push * (route_items + order_items + stall_items + fair_items);
  localparam int timeout_limit = 20 * total_items + 200;

  // how a source picks destinations
  localparam int mode_route = 0;
  localparam int mode_random = 1;
  localparam int mode_fair = 2;

  // the one pop flow every source hits in the fairness test
  localparam int fair_dest = 2;

  logic clk;
  logic rst_n;
  logic [n_push-1:0] push_valid;
  logic [n_push-1:0] push_ready;
  xbar_pkg::flow_data_t [n_push-1:0] push_data;
  xbar_pkg::dest_id_t [n_push-1:0] push_dest_id;
  logic [n_pop-1:0] pop_valid;
  logic [n_pop-1:0] pop_ready;
  xbar_pkg::flow_data_t [n_pop-1:0] pop_data;

  // expected items in push order, indexed by source then destination
  xbar_pkg::flow_data_t exp_q [n_push][n_pop][$];

  // sources of the latest pops on the contended flow
  xbar_pkg::push_id_t fair_hist [$];

  int errors;
  int pushed;
  int popped;
  int tests;
  int cycle;
  bit stall_on = 1'b0;
  bit fair_on = 1'b0;

  flow_xbar uut (
    .clk(clk),
    .rst_n(rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data(push_data),
    .push_dest_id(push_dest_id),
    .pop_valid(pop_valid),
    .pop_ready(pop_ready),
    .pop_data(pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // hard stop if traffic never drains
  always @(posedge clk) begin
    cycle++;
    if (cycle >= timeout_limit) begin
      $display("timeout: run still busy after %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // consumer side, random stalls only in the back-pressure test
  initial begin
    pop_ready = '1;
    forever begin
      @(negedge clk);
      pop_ready = stall_on ? n_pop'($urandom) : '1;
    end
  end

  // low bits name the source, the rest is random
  function automatic xbar_pkg::flow_data_t make_item(input int src);
    return xbar_pkg::flow_data_t'({$urandom(), xbar_pkg::push_id_t'(src)});
  endfunction

  // reference model: head of the queue for the item's source and this destination
  function automatic xbar_pkg::flow_data_t expected_item(
    input xbar_pkg::flow_data_t got, input int dst);
    xbar_pkg::push_id_t src;
    src = xbar_pkg::push_id_t'(got);
    return exp_q[src][dst][0];
  endfunction

  // destination an item was pushed to, the popping flow searched first
  function automatic int find_dest(input xbar_pkg::flow_data_t got, input int pref);
    xbar_pkg::push_id_t src;
    src = xbar_pkg::push_id_t'(got);
    for (int k = 0; k < exp_q[src][pref].size(); k++) begin
      if (exp_q[src][pref][k] == got) return pref;
    end
    for (int d = 0; d < n_pop; d++) begin
      for (int k = 0; k < exp_q[src][d].size(); k++) begin
        if (exp_q[src][d][k] == got) return d;
      end
    end
    return -1;
  endfunction

  task automatic check_data(input string name, input xbar_pkg::flow_data_t got,
                            input xbar_pkg::flow_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dest(input string name, input xbar_pkg::dest_id_t got,
                            input xbar_pkg::dest_id_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // one pop transfer against the reference queues
  task automatic compare_pop(input int dst, input xbar_pkg::flow_data_t got);
    xbar_pkg::push_id_t src;
    int found;
    logic [n_push-1:0] seen;
    src = xbar_pkg::push_id_t'(got);
    found = find_dest(got, dst);
    popped++;
    if (found < 0) begin
      $display("pop %0d delivered 0x%h, which no source has outstanding", dst, got);
      errors++;
    end else begin
      check_dest($sformatf("pop_dest[%0d]", dst), xbar_pkg::dest_id_t'(dst),
                 xbar_pkg::dest_id_t'(found));
      check_data($sformatf("pop_data[%0d]", dst), got, expected_item(got, found));
      exp_q[src][found].delete(0);
    end
    // every window of four pops must hold all four sources
    if (fair_on && dst == fair_dest) begin
      fair_hist.push_back(src);
      if (fair_hist.size() > n_push) fair_hist.delete(0);
      seen = '0;
      for (int k = 0; k < fair_hist.size(); k++) seen[fair_hist[k]] = 1'b1;
      if (fair_hist.size() == n_push && seen != '1) begin
        $display("pop %0d served a source twice within four transfers", dst);
        errors++;
      end
    end
  endtask

  // compare process, pushes recorded before pops in the same edge
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < n_push; i++) begin
        if (push_valid[i] && push_ready[i]) begin
          exp_q[i][push_dest_id[i]].push_back(push_data[i]);
          pushed++;
        end
      end
      for (int j = 0; j < n_pop; j++) begin
        if (pop_valid[j] && pop_ready[j]) compare_pop(j, pop_data[j]);
      end
    end
  end

  // offer one item and hold it until the push port takes it
  task automatic send(input int src, input xbar_pkg::dest_id_t dst);
    @(negedge clk);
    push_valid[src] = 1'b1;
    push_data[src] = make_item(src);
    push_dest_id[src] = dst;
    do begin
      @(posedge clk);
    end while (!push_ready[src]);
  endtask

  task automatic release_push(input int src);
    @(negedge clk);
    push_valid[src] = 1'b0;
  endtask

  task automatic run_source(input int src, input int count, input int mode);
    xbar_pkg::dest_id_t dst;
    for (int n = 0; n < count; n++) begin
      case (mode)
        mode_route: dst = xbar_pkg::dest_id_t'(n + src);
        mode_fair: dst = xbar_pkg::dest_id_t'(fair_dest);
        default: dst = xbar_pkg::dest_id_t'($urandom);
      endcase
      send(src, dst);
      // random idle gaps, none under contention
      if (mode == mode_random && $urandom_range(3) == 0) release_push(src);
    end
    release_push(src);
  endtask

  task automatic wait_drained();
    while (pushed != popped) @(negedge clk);
    for (int i = 0; i < n_push; i++) begin
      for (int j = 0; j < n_pop; j++) begin
        if (exp_q[i][j].size() != 0) begin
          $display("source %0d to pop %0d still has %0d items queued", i, j,
                   exp_q[i][j].size());
          errors++;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests++;
    if (errors == start_err) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - start_err);
  endtask

  task automatic run_test(input string name, input int count, input int mode);
    int start_err;
    start_err = errors;
    for (int i = 0; i < n_push; i++) begin
      automatic int s = i;
      fork
        run_source(s, count, mode);
      join_none
    end
    wait fork;
    wait_drained();
    report_test(name, start_err);
  endtask

  // single item through an idle path, two register stages
  task automatic test_latency();
    int start_err;
    int edges;
    start_err = errors;
    send(0, xbar_pkg::dest_id_t'(1));
    release_push(0);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
    end while (!pop_valid[1]);
    if (edges != 2) begin
      $display("latency: item reached pop 1 after %0d cycles instead of 2", edges);
      errors++;
    end
    wait_drained();
    report_test("latency", start_err);
  endtask

  initial begin
    void'($urandom(32'h7870_5f74));
    rst_n = 1'b0;
    push_valid = '0;
    push_data = '0;
    push_dest_id = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_latency();
    run_test("routing", route_items, mode_route);
    run_test("order", order_items, mode_random);
    stall_on = 1'b1;
    run_test("back-pressure", stall_items, mode_random);
    stall_on = 1'b0;
    fair_hist.delete();
    fair_on = 1'b1;
    run_test("fairness", fair_items, mode_fair);
    fair_on = 1'b0;
    $display("tests %0d, pushed %0d, popped %0d, errors %0d", tests, pushed, popped, errors);
    if (errors == 0 && pushed == popped) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sources.f
source/xbar_pkg.sv
source/flow_if.sv
source/flow_reg.sv
source/flow_demux.sv
source/rr_arbiter.sv
source/flow_mux.sv
source/flow_xbar.sv
sim/flow_xbar_checker.sv
sim/flow_xbar_tb.sv

//--- Makefile
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: obj_dir/Vflow_xbar_tb
	@out=$$(./obj_dir/Vflow_xbar_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

obj_dir/V%: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module $* -f sources.f -Mdir obj_dir

clean:
	rm -rf obj_dir
